//--- Makefile
TOOL       = verilator
FLAGS      = --binary --assert --timing
LINT_FLAGS = --lint-only --assert --timing
TOP        = wbufTb
FLIST      = flist.f
SIM_ARGS   = +verilator+error+limit+1000
PASS_MSG   = === PASS ===

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP)
	./obj_dir/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- flist.f
+incdir+.
wbufPkg.sv
wbufSlotIf.sv
wbufCtrlIf.sv
wbufSlot.sv
wbufSlavePort.sv
wbufMasterPort.sv
wbufTop.sv
wbuf_asserts.sv
wbufTbClk.sv
wbufTb.sv

//--- wbufCtrlIf.sv
/* Control interface between slave and master ports
   Read requests, flush requests and read responses */
`timescale 1ns/1ns
`default_nettype none

interface wbufCtrlIf;

   // Read request, registered address and SEL
   logic               readStb;
   wbufPkg::wbAddr_t   readAdr;
   wbufPkg::wbSel_t    readSel;

   // Level request to drain the slots
   logic               flushReq;

   // Master side status and read response
   logic               busy;
   logic               readAck;
   logic               readErr;
   wbufPkg::wbData_t   readData;

   modport slave  (output readStb, readAdr, readSel, flushReq,
                   input  busy, readAck, readErr, readData);
   modport master (input  readStb, readAdr, readSel, flushReq,
                   output busy, readAck, readErr, readData);

endinterface

`default_nettype wire

//--- wbufMasterPort.sv
/* Write buffer master port
   FSM that drains the slots in order with burst CTI, then runs queued reads */
`timescale 1ns/1ns
`default_nettype none

`include "wbuf_consts.svh"

module wbufMasterPort
(
   input  wire                         CLK,
   input  wire                         RST_ASYNC,

   // Wishbone master
   output wbufPkg::wbAddr_t            mAdr,
   output logic                        mCyc,
   output logic                        mStb,
   output logic                        mWe,
   output wbufPkg::wbSel_t             mSel,
   output wbufPkg::wbCti_t             mCti,
   output wbufPkg::wbData_t            mDatWr,
   input  wire                         mAck,
   input  wire                         mStall,
   input  wire                         mErr,
   input  wire wbufPkg::wbData_t       mDatRd,

   // Bottom two slots, all valid flags, slave port
   wbufSlotIf.drain                    slot0,
   wbufSlotIf.drain                    slot1,
   input  wire wbufPkg::slotVec_t      slotValid,
   wbufCtrlIf.master                   ctrl
);

   localparam int OUT_W = $clog2(`WBUF_DEPTH + 1);

   wbufPkg::masterState_e  state;
   wbufPkg::masterState_e  stateNext;
   wbufPkg::masterState_e  idleNext;
   logic                   readPend;
   logic                   readIssued;
   logic [OUT_W-1:0]       outstanding;
   wbufPkg::wbCti_t        lastCti;
   wbufPkg::wbCti_t        flushCti;
   wbufPkg::wbWordAddr_t   nextWord;
   logic                   burstNext;
   logic                   flushBeat;
   logic                   flushAck;
   logic                   flushDone;
   logic                   readDone;

   ////////////////////////////////////////
   // Events
   ////////////////////////////////////////

   // Beat accepted, and slots shift down on the same edge
   assign flushBeat   = (state == wbufPkg::MS_FLUSH) && slot0.valid && !mStall;
   assign slot0.shift = flushBeat;

   // ERR on a flush write still closes the beat
   assign flushAck  = (state == wbufPkg::MS_FLUSH) && (mAck || mErr);
   assign flushDone = (state == wbufPkg::MS_FLUSH) && !(|slotValid)
                      && ((outstanding == '0)
                          || ((outstanding == OUT_W'(1)) && flushAck));
   assign readDone  = (state == wbufPkg::MS_READ) && (mAck || mErr);

   ////////////////////////////////////////
   // State machine
   ////////////////////////////////////////

   // Choice from idle, also used on read completion
   always_comb
   begin
      if (ctrl.flushReq)
      begin
         idleNext = wbufPkg::MS_FLUSH;
      end
      else if (ctrl.readStb)
      begin
         idleNext = wbufPkg::MS_READ;
      end
      else
      begin
         idleNext = wbufPkg::MS_IDLE;
      end
   end

   always_comb
   begin
      stateNext = state;
      case (state)
         wbufPkg::MS_IDLE:
            stateNext = idleNext;
         wbufPkg::MS_FLUSH:
            if (flushDone)
            begin
               // Queued read goes straight after the last write
               stateNext = readPend ? wbufPkg::MS_READ : wbufPkg::MS_IDLE;
            end
         wbufPkg::MS_READ:
            if (readDone)
            begin
               stateNext = idleNext;
            end
         default:
            stateNext = wbufPkg::MS_IDLE;
      endcase
   end

   always_ff @(posedge CLK or posedge RST_ASYNC)
   begin
      if (RST_ASYNC)
      begin
         state       <= wbufPkg::MS_IDLE;
         readPend    <= 1'b0;
         readIssued  <= 1'b0;
         outstanding <= '0;
         lastCti     <= `WBUF_CTI_CLASSIC;
      end
      else
      begin
         state <= stateNext;
         // Read held behind the flush it triggered
         if (ctrl.readStb && ctrl.flushReq)
         begin
            readPend <= 1'b1;
         end
         else if (flushDone)
         begin
            readPend <= 1'b0;
         end
         // Single read strobe per read cycle
         readIssued <= (state == wbufPkg::MS_READ) && !readDone && (readIssued || !mStall);
         // Flush beats still waiting for a response
         if (flushBeat && !flushAck)
         begin
            outstanding <= outstanding + OUT_W'(1);
         end
         else if (!flushBeat && flushAck)
         begin
            outstanding <= outstanding - OUT_W'(1);
         end
         // CTI of the last accepted beat
         if (state != wbufPkg::MS_FLUSH)
         begin
            lastCti <= `WBUF_CTI_CLASSIC;
         end
         else if (flushBeat)
         begin
            lastCti <= flushCti;
         end
      end
   end

   ////////////////////////////////////////
   // Burst CTI decode
   ////////////////////////////////////////

   assign nextWord  = slot0.wordAddr + wbufPkg::wbWordAddr_t'(1);
   // Next entry is the following word and both are full words
   assign burstNext = slot1.valid && (slot1.wordAddr == nextWord)
                      && (&slot0.sel) && (&slot1.sel);

   always_comb
   begin
      if (burstNext)
      begin
         flushCti = `WBUF_CTI_INCR;
      end
      else if (lastCti == `WBUF_CTI_INCR)
      begin
         flushCti = `WBUF_CTI_END;
      end
      else
      begin
         flushCti = `WBUF_CTI_CLASSIC;
      end
   end

   ////////////////////////////////////////
   // Master outputs
   ////////////////////////////////////////

   assign mCyc   = (state != wbufPkg::MS_IDLE);
   assign mWe    = (state == wbufPkg::MS_FLUSH);
   assign mDatWr = slot0.data;

   always_comb
   begin
      mAdr = ctrl.readAdr;
      mSel = ctrl.readSel;
      mCti = `WBUF_CTI_CLASSIC;
      mStb = 1'b0;
      case (state)
         wbufPkg::MS_FLUSH:
         begin
            mAdr = {slot0.wordAddr, 2'b00};
            mSel = slot0.sel;
            mCti = flushCti;
            mStb = slot0.valid;
         end
         wbufPkg::MS_READ:
            mStb = !readIssued;
         default:
            mStb = 1'b0;
      endcase
   end

   // Read response back to the slave side
   assign ctrl.busy     = (state == wbufPkg::MS_FLUSH)
                          || ((state == wbufPkg::MS_READ) && !readDone);
   assign ctrl.readAck  = (state == wbufPkg::MS_READ) && mAck;
   assign ctrl.readErr  = (state == wbufPkg::MS_READ) && mErr;
   assign ctrl.readData = mDatRd;

endmodule

`default_nettype wire

//--- wbufPkg.sv
/* Write buffer package
   Bus width types and the master port state encoding */
`default_nettype none

`include "wbuf_consts.svh"

package wbufPkg;

   // Byte and word addresses
   typedef logic [`WBUF_ADDR_W-1:0] wbAddr_t;
   typedef logic [`WBUF_ADDR_W-3:0] wbWordAddr_t;

   // Payload and byte lanes
   typedef logic [`WBUF_DATA_W-1:0] wbData_t;
   typedef logic [`WBUF_SEL_W-1:0]  wbSel_t;

   // Cycle type
   typedef logic [2:0] wbCti_t;

   // One flag per slot
   typedef logic [`WBUF_DEPTH-1:0] slotVec_t;

   // Master port states
   typedef enum logic [1:0] {
      MS_IDLE  = 2'd0,
      MS_FLUSH = 2'd1,
      MS_READ  = 2'd2
   } masterState_e;

endpackage

`default_nettype wire

//--- wbufSlavePort.sv
/* Write buffer slave port
   Decodes slave strobes, steers writes into slots, queues reads for the master */
`timescale 1ns/1ns
`default_nettype none

`include "wbuf_consts.svh"

module wbufSlavePort
(
   input  wire                       CLK,
   input  wire                       RST_ASYNC,

   // Wishbone slave
   input  wire wbufPkg::wbAddr_t     sAdr,
   input  wire                       sCyc,
   input  wire                       sStb,
   input  wire                       sWe,
   input  wire wbufPkg::wbSel_t      sSel,
   input  wire wbufPkg::wbData_t     sDatWr,
   output logic                      sStall,
   output logic                      sAck,
   output logic                      sErr,
   output wbufPkg::wbData_t          sDatRd,

   // Slots and master port
   wbufSlotIf.feed                   slots [`WBUF_DEPTH],
   wbufCtrlIf.slave                  ctrl
);

   wbufPkg::slotVec_t slotValid;
   wbufPkg::slotVec_t slotMatch;
   wbufPkg::slotVec_t loadVec;
   logic              writeAcc;
   logic              readAcc;
   logic              wrAck;

   ////////////////////////////////////////
   // Slave decode
   ////////////////////////////////////////

   // Request taken when strobed and not stalled
   assign writeAcc = sCyc & sStb &  sWe & ~sStall;
   assign readAcc  = sCyc & sStb & ~sWe & ~sStall;

   // Buffer full, or master draining or reading
   assign sStall = slotValid[`WBUF_DEPTH-1] | ctrl.busy;

   // Write ack is registered, read response is passed through
   assign sAck   = wrAck | ctrl.readAck;
   assign sErr   = ctrl.readErr;
   assign sDatRd = ctrl.readData;

   ////////////////////////////////////////
   // Slot feed
   ////////////////////////////////////////

   genvar i;
   generate
      for (i = 0; i < `WBUF_DEPTH; i++)
      begin : gFeed
         assign slotValid[i]        = slots[i].valid;
         assign slotMatch[i]        = slots[i].match;
         assign slots[i].load       = loadVec[i];
         // Word address, SEL and data go to every slot
         assign slots[i].wrWordAddr = sAdr[`WBUF_ADDR_W-1:2];
         assign slots[i].wrSel      = sSel;
         assign slots[i].wrData     = sDatWr;
      end
   endgenerate

   // Merge into the lowest hit, else fill the lowest free slot
   always_comb
   begin
      loadVec = '0;
      if (writeAcc)
      begin
         if (|slotMatch)
         begin
            loadVec = slotMatch & ~(slotMatch - wbufPkg::slotVec_t'(1));
         end
         else
         begin
            // Lowest clear bit of the valid vector
            loadVec = ~slotValid & (slotValid + wbufPkg::slotVec_t'(1));
         end
      end
   end

   // Write ack one cycle after acceptance
   always_ff @(posedge CLK or posedge RST_ASYNC)
   begin
      if (RST_ASYNC)
      begin
         wrAck <= 1'b0;
      end
      else
      begin
         wrAck <= writeAcc;
      end
   end

   ////////////////////////////////////////
   // Read capture
   ////////////////////////////////////////

   // Held until the master issues the read
   always_ff @(posedge CLK)
   begin
      if (readAcc)
      begin
         ctrl.readAdr <= sAdr;
         ctrl.readSel <= sSel;
      end
   end

   assign ctrl.readStb = readAcc;

   // Drain when full, or when a read would bypass held writes
   assign ctrl.flushReq = slotValid[`WBUF_DEPTH-1] | (readAcc & slotValid[0]);

endmodule

`default_nettype wire

//--- wbufSlot.sv
/* Write buffer slot
   One entry that merges writes to its word, loads new ones and shifts down */
`timescale 1ns/1ns
`default_nettype none

`include "wbuf_consts.svh"

module wbufSlot
#(
   parameter bit IS_TOP = 1'b0
)
(
   input  wire          CLK,
   input  wire          RST_ASYNC,
   wbufSlotIf.slot      own,
   wbufSlotIf.drain     above
);

   localparam int BYTE_W = `WBUF_DATA_W / `WBUF_SEL_W;

   // Contents taken on a shift
   logic                  shiftValid;
   wbufPkg::wbWordAddr_t  shiftAddr;
   wbufPkg::wbSel_t       shiftSel;
   wbufPkg::wbData_t      shiftData;

   generate
      if (IS_TOP)
      begin : gTop
         // Nothing above, so the slot empties
         assign shiftValid = 1'b0;
         assign shiftAddr  = '0;
         assign shiftSel   = '0;
         assign shiftData  = '0;
      end
      else
      begin : gMid
         assign shiftValid  = above.valid;
         assign shiftAddr   = above.wordAddr;
         assign shiftSel    = above.sel;
         assign shiftData   = above.data;
         // Pass shift on to the slot above
         assign above.shift = own.shift;
      end
   endgenerate

   // Hit on a held entry with the same word
   assign own.match = own.valid && (own.wordAddr == own.wrWordAddr);

   // Valid flag, shift wins over load
   always_ff @(posedge CLK or posedge RST_ASYNC)
   begin
      if (RST_ASYNC)
      begin
         own.valid <= 1'b0;
      end
      else if (own.shift)
      begin
         own.valid <= shiftValid;
      end
      else if (own.load)
      begin
         own.valid <= 1'b1;
      end
   end

   // Payload
   always_ff @(posedge CLK)
   begin
      if (own.shift)
      begin
         own.wordAddr <= shiftAddr;
         own.sel      <= shiftSel;
         own.data     <= shiftData;
      end
      else if (own.load)
      begin
         own.wordAddr <= own.wrWordAddr;
         // SELs accumulate only on a held entry
         own.sel      <= (own.valid ? own.sel : '0) | own.wrSel;
         // Enabled lanes overwrite, others keep old bytes
         for (int b = 0; b < `WBUF_SEL_W; b++)
         begin
            if (own.wrSel[b])
            begin
               own.data[b*BYTE_W +: BYTE_W] <= own.wrData[b*BYTE_W +: BYTE_W];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- wbufSlotIf.sv
/* Slot interface
   One entry's contents and match flag, with the write bundle and controls */
`timescale 1ns/1ns
`default_nettype none

interface wbufSlotIf;

   // Entry contents, owned by the slot
   logic                  valid;
   wbufPkg::wbWordAddr_t  wordAddr;
   wbufPkg::wbSel_t       sel;
   wbufPkg::wbData_t      data;
   // Incoming write hits this entry
   logic                  match;

   // Write bundle from the slave port, same on every slot
   logic                  load;
   wbufPkg::wbWordAddr_t  wrWordAddr;
   wbufPkg::wbSel_t       wrSel;
   wbufPkg::wbData_t      wrData;

   // Shift down, common to all slots
   logic                  shift;

   modport slot  (output valid, wordAddr, sel, data, match,
                  input  load, wrWordAddr, wrSel, wrData, shift);
   modport feed  (input  valid, match,
                  output load, wrWordAddr, wrSel, wrData);
   modport drain (input  valid, wordAddr, sel, data,
                  output shift);

endinterface

`default_nettype wire

//--- wbufTb.sv
/* Write buffer testbench
   Drives merges, full flushes, bursts and reads against a memory slave model */
`timescale 1ns/1ns
`default_nettype none

`include "wbuf_consts.svh"

module wbufTb;

   // Roughly 40 transactions of up to 16 cycles plus margin
   localparam int TIMEOUT_NS = 40 * 16 * 20 + 4000;

   wire                CLK;
   wire                RST_ASYNC;
   logic               sCyc, sStb, sWe;
   wbufPkg::wbAddr_t   sAdr;
   wbufPkg::wbSel_t    sSel;
   wbufPkg::wbData_t   sDatWr, sDatRd;
   logic               sStall, sAck, sErr;
   wbufPkg::wbAddr_t   mAdr;
   logic               mCyc, mStb, mWe, mAck, mStall, mErr;
   wbufPkg::wbSel_t    mSel;
   wbufPkg::wbCti_t    mCti;
   wbufPkg::wbData_t   mDatWr, mDatRd;

   // Expected slot contents in arrival order
   wbufPkg::wbWordAddr_t qAddr [$];
   wbufPkg::wbSel_t      qSel [$];
   wbufPkg::wbData_t     qData [$];
   wbufPkg::wbCti_t      lastCtiExp;

   wbufPkg::wbData_t     mem [0:255];
   integer               seed = 48;
   int                   errCount;
   logic                 errInject;
   logic                 readWait;
   logic                 ackDue;
   wbufPkg::wbAddr_t     readAddrExp;
   wbufPkg::wbAddr_t     rAdr;
   wbufPkg::wbSel_t      rSel;

   wbufTbClk uClk (.CLK(CLK), .RST_ASYNC(RST_ASYNC));

   wbufTop u_dut
   (
      .CLK, .RST_ASYNC,
      .sAdr, .sCyc, .sStb, .sWe, .sSel, .sDatWr, .sDatRd, .sStall, .sAck, .sErr,
      .mAdr, .mCyc, .mStb, .mWe, .mSel, .mCti, .mDatWr, .mAck, .mStall, .mErr, .mDatRd
   );

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic wbufPkg::wbData_t laneMask(input wbufPkg::wbSel_t sel);
      wbufPkg::wbData_t m;
      for (int b = 0; b < `WBUF_SEL_W; b++)
      begin
         m[b*8 +: 8] = {8{sel[b]}};
      end
      return m;
   endfunction

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         errCount++;
         $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Merge into a held word, else append a new entry
   task automatic modelWrite(input wbufPkg::wbAddr_t a, input wbufPkg::wbSel_t s,
                             input wbufPkg::wbData_t d);
      int hit;
      hit = -1;
      foreach (qAddr[k])
      begin
         if (hit < 0 && qAddr[k] == a[31:2])
         begin
            hit = k;
         end
      end
      if (hit < 0)
      begin
         qAddr.push_back(a[31:2]);
         qSel.push_back(s);
         qData.push_back(d);
      end
      else
      begin
         qSel[hit]  = qSel[hit] | s;
         qData[hit] = (qData[hit] & ~laneMask(s)) | (d & laneMask(s));
      end
   endtask

   // Burst when the next entry is the following full word
   function automatic wbufPkg::wbCti_t expCti();
      if (qAddr.size() > 1 && qAddr[1] == qAddr[0] + wbufPkg::wbWordAddr_t'(1)
          && (&qSel[0]) && (&qSel[1]))
      begin
         return `WBUF_CTI_INCR;
      end
      else if (lastCtiExp == `WBUF_CTI_INCR)
      begin
         return `WBUF_CTI_END;
      end
      return `WBUF_CTI_CLASSIC;
   endfunction

   ////////////////////////////////////////
   // Memory slave
   ////////////////////////////////////////

   initial
   begin
      mAck   = 1'b0;
      mErr   = 1'b0;
      mStall = 1'b0;
      mDatRd = '0;
      for (int i = 0; i < 256; i++)
      begin
         mem[i] = 32'hC3000000 ^ (i * 32'h00010101);
      end
   end

   // Beat sampled before the edge is answered one cycle later
   always @(negedge CLK)
   begin
      logic take;
      logic we;
      wbufPkg::wbAddr_t adr;
      take = mCyc && mStb && !mStall && !RST_ASYNC;
      we   = mWe;
      adr  = mAdr;
      if (take && we)
      begin
         mem[adr[9:2]] = (mem[adr[9:2]] & ~laneMask(mSel)) | (mDatWr & laneMask(mSel));
      end
      @(posedge CLK);
      #2;
      mAck   = take && !(errInject && !we);
      mErr   = take && errInject && !we;
      mDatRd = mem[adr[9:2]];
      mStall = (($random(seed) & 3) == 0);
   end

   ////////////////////////////////////////
   // Monitor
   ////////////////////////////////////////

   always @(negedge CLK)
   begin
      if (!RST_ASYNC)
      begin
         // Write ack exactly one cycle after acceptance and never otherwise
         if (ackDue)
         begin
            checkValue("sAck", 32'(sAck), 32'(1'b1));
         end
         else if (!readWait)
         begin
            checkValue("sAck", 32'(sAck), 32'(1'b0));
         end
         // Master write beat against the model head
         if (mCyc && mStb && !mStall && mWe)
         begin
            assert (qAddr.size() > 0)
            else
            begin
               errCount++;
               $display("Flush beat issued with no write held at %0t", $time);
            end
            if (qAddr.size() > 0)
            begin
               checkValue("mAdr", mAdr, {qAddr[0], 2'b00});
               checkValue("mSel", 32'(mSel), 32'(qSel[0]));
               checkValue("mDatWr", mDatWr & laneMask(qSel[0]), qData[0] & laneMask(qSel[0]));
               checkValue("mCti", 32'(mCti), 32'(expCti()));
               lastCtiExp = expCti();
               void'(qAddr.pop_front());
               void'(qSel.pop_front());
               void'(qData.pop_front());
            end
         end
         else if (!(mCyc && mWe))
         begin
            lastCtiExp = `WBUF_CTI_CLASSIC;
         end
         // Read beat only after every held write left
         if (mCyc && mStb && !mStall && !mWe)
         begin
            assert (qAddr.size() == 0)
            else
            begin
               errCount++;
               $display("Read issued before held writes at %0t", $time);
            end
            checkValue("mAdr", mAdr, readAddrExp);
         end
         if (readWait && (sAck || sErr))
         begin
            checkValue("sErr", 32'(sErr), 32'(errInject));
            if (!errInject)
            begin
               checkValue("sDatRd", sDatRd, mem[readAddrExp[9:2]]);
            end
            readWait = 1'b0;
         end
         ackDue = sCyc && sStb && sWe && !sStall;
         if (ackDue)
         begin
            modelWrite(sAdr, sSel, sDatWr);
         end
         if (sCyc && sStb && !sWe && !sStall)
         begin
            readWait    = 1'b1;
            readAddrExp = sAdr;
         end
      end
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   task automatic acceptReq();
      @(negedge CLK);
      while (sStall)
      begin
         @(negedge CLK);
      end
      @(posedge CLK);
      #2;
      sCyc = 1'b0;
      sStb = 1'b0;
      sWe  = 1'b0;
   endtask

   task automatic writeWord(input wbufPkg::wbAddr_t a, input wbufPkg::wbSel_t s,
                            input wbufPkg::wbData_t d);
      sCyc   = 1'b1;
      sStb   = 1'b1;
      sWe    = 1'b1;
      sAdr   = a;
      sSel   = s;
      sDatWr = d;
      acceptReq();
   endtask

   task automatic readWord(input wbufPkg::wbAddr_t a, input logic inject);
      errInject = inject;
      sCyc = 1'b1;
      sStb = 1'b1;
      sWe  = 1'b0;
      sAdr = a;
      sSel = 4'hF;
      acceptReq();
      while (readWait)
      begin
         @(posedge CLK);
      end
      #2;
      errInject = 1'b0;
   endtask

   // Full buffer stalls before the flush cycle starts
   task automatic waitIdle();
      @(negedge CLK);
      while (mCyc || sStall)
      begin
         @(negedge CLK);
      end
      @(posedge CLK);
      #2;
   endtask

   initial
   begin
      sCyc = 1'b0;
      sStb = 1'b0;
      sWe = 1'b0;
      sAdr = '0;
      sSel = '0;
      sDatWr = '0;
      errCount = 0;
      errInject = 1'b0;
      readWait = 1'b0;
      ackDue = 1'b0;
      lastCtiExp = `WBUF_CTI_CLASSIC;
      @(negedge RST_ASYNC);
      @(negedge CLK);
      checkValue("sStall", 32'(sStall), 32'(1'b0));
      checkValue("sAck", 32'(sAck), 32'(1'b0));
      checkValue("sErr", 32'(sErr), 32'(1'b0));
      checkValue("mCyc", 32'(mCyc), 32'(1'b0));
      checkValue("mStb", 32'(mStb), 32'(1'b0));
      @(posedge CLK);
      #2;
      // Three merged writes flushed by a read
      writeWord(32'h100, 4'b0001, 32'h11111111);
      writeWord(32'h100, 4'b0110, 32'h22222222);
      writeWord(32'h100, 4'b0011, 32'h33333333);
      readWord(32'h100, 1'b0);
      // Full buffer of scattered words gives classic beats
      for (int k = 0; k < `WBUF_DEPTH; k++)
      begin
         writeWord(32'h200 + k * 8, 4'hF, 32'hA0000000 + k);
      end
      waitIdle();
      // Full word burst
      for (int k = 0; k < `WBUF_DEPTH; k++)
      begin
         writeWord(32'h300 + k * 4, 4'hF, 32'hB0000000 + k);
      end
      waitIdle();
      // Short burst followed by a stray word
      writeWord(32'h340, 4'hF, 32'hD0000001);
      writeWord(32'h344, 4'hF, 32'hD0000002);
      writeWord(32'h380, 4'hF, 32'hD0000003);
      readWord(32'h344, 1'b0);
      // Bus error on a read with an empty buffer
      readWord(32'h304, 1'b1);
      // Random merges on a few words
      repeat (12)
      begin
         rAdr = 32'h400 + (($random(seed) & 7) << 2);
         rSel = 4'($random(seed));
         if (rSel == 4'h0)
         begin
            rSel = 4'h1;
         end
         writeWord(rAdr, rSel, $random(seed));
      end
      readWord(32'h400, 1'b0);
      waitIdle();
      repeat (3) @(posedge CLK);
      $display("Checks done: %0d testbench errors, %0d assertion failures",
               errCount, u_dut.uAsserts.failCount);
      if (errCount == 0 && u_dut.uAsserts.failCount == 0)
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog
   initial
   begin
      #(TIMEOUT_NS);
      $display("Watchdog expired, the run did not finish in time");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- wbufTbClk.sv
/* Testbench clock and reset
   20 ns clock, reset held for the first 4 cycles */
`timescale 1ns/1ns
`default_nettype none

module wbufTbClk
(
   output logic CLK,
   output logic RST_ASYNC
);

   // Free running clock
   initial
   begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   // Release just after the fourth rising edge
   initial
   begin
      RST_ASYNC = 1'b1;
      repeat (4) @(posedge CLK);
      #2 RST_ASYNC = 1'b0;
   end

endmodule

`default_nettype wire

//--- wbufTop.sv
/* Wishbone write buffer
   Merges and holds writes in front of a memory slave, flushing before reads */
`timescale 1ns/1ns
`default_nettype none

`include "wbuf_consts.svh"

module wbufTop
(
   input  wire                    CLK,
   input  wire                    RST_ASYNC,

   // Wishbone slave side
   input  wire wbufPkg::wbAddr_t  sAdr,
   input  wire                    sCyc,
   input  wire                    sStb,
   input  wire                    sWe,
   input  wire wbufPkg::wbSel_t   sSel,
   input  wire wbufPkg::wbData_t  sDatWr,
   output wbufPkg::wbData_t       sDatRd,
   output logic                   sStall,
   output logic                   sAck,
   output logic                   sErr,

   // Wishbone master side
   output wbufPkg::wbAddr_t       mAdr,
   output logic                   mCyc,
   output logic                   mStb,
   output logic                   mWe,
   output wbufPkg::wbSel_t        mSel,
   output wbufPkg::wbCti_t        mCti,
   output wbufPkg::wbData_t       mDatWr,
   input  wire                    mAck,
   input  wire                    mStall,
   input  wire                    mErr,
   input  wire wbufPkg::wbData_t  mDatRd
);

   // One interface per slot, slot 0 drains first
   wbufSlotIf          slotIf [`WBUF_DEPTH] ();
   wbufCtrlIf          ctrlIf ();
   wbufPkg::slotVec_t  slotValid;

   wbufSlavePort uSlavePort
   (
      .CLK, .RST_ASYNC,
      .sAdr, .sCyc, .sStb, .sWe, .sSel, .sDatWr,
      .sStall, .sAck, .sErr, .sDatRd,
      .slots (slotIf),
      .ctrl  (ctrlIf)
   );

   ////////////////////////////////////////
   // Slot chain
   ////////////////////////////////////////

   genvar i;
   generate
      for (i = 0; i < `WBUF_DEPTH; i++)
      begin : gSlot
         assign slotValid[i] = slotIf[i].valid;
         if (i == `WBUF_DEPTH - 1)
         begin : gTop
            // Top slot has nothing above it
            wbufSlot #(.IS_TOP(1'b1)) uSlot
            (
               .CLK, .RST_ASYNC,
               .own   (slotIf[i]),
               .above (slotIf[i])
            );
         end
         else
         begin : gMid
            wbufSlot #(.IS_TOP(1'b0)) uSlot
            (
               .CLK, .RST_ASYNC,
               .own   (slotIf[i]),
               .above (slotIf[i+1])
            );
         end
      end
   endgenerate

   wbufMasterPort uMasterPort
   (
      .CLK, .RST_ASYNC,
      .mAdr, .mCyc, .mStb, .mWe, .mSel, .mCti, .mDatWr,
      .mAck, .mStall, .mErr, .mDatRd,
      .slot0     (slotIf[0]),
      .slot1     (slotIf[1]),
      .slotValid (slotValid),
      .ctrl      (ctrlIf)
   );

endmodule

`default_nettype wire

//--- wbuf_asserts.sv
/* Write buffer protocol checks
   Concurrent assertions bound into the top level */
`timescale 1ns/1ns
`default_nettype none

`include "wbuf_consts.svh"

module wbufAsserts
(
   input wire                   CLK,
   input wire                   RST_ASYNC,
   input wire                   sCyc,
   input wire                   sStb,
   input wire                   sWe,
   input wire                   sStall,
   input wire                   sAck,
   input wire                   mCyc,
   input wire                   mStb,
   input wire                   mWe,
   input wire                   mStall,
   input wire wbufPkg::wbAddr_t mAdr,
   input wire wbufPkg::wbSel_t  mSel,
   input wire wbufPkg::wbCti_t  mCti
);

   // Failure count read by the testbench top
   int failCount = 0;

   ////////////////////////////////////////
   // Slave side
   ////////////////////////////////////////

   // Accepted write acked on the next cycle
   aWrAck : assert property (@(posedge CLK) disable iff (RST_ASYNC)
      (sCyc && sStb && sWe && !sStall) |=> sAck)
   else
   begin
      failCount++;
      $error("write accepted but not acked on the next cycle");
   end

   // Full buffer on an idle bus starts a flush on the next cycle
   aFullFlush : assert property (@(posedge CLK) disable iff (RST_ASYNC)
      (sStall && !mCyc) |=> (mCyc && mWe))
   else
   begin
      failCount++;
      $error("full buffer did not start a flush");
   end

   // Stall drops only once the flush cycle has ended
   aStallHold : assert property (@(posedge CLK) disable iff (RST_ASYNC)
      $fell(sStall) |-> (!mCyc || !$past(mWe)))
   else
   begin
      failCount++;
      $error("sStall dropped during a flush");
   end

   ////////////////////////////////////////
   // Master side
   ////////////////////////////////////////

   // Stalled beat is held unchanged
   aHold : assert property (@(posedge CLK) disable iff (RST_ASYNC)
      (mStb && mStall) |=> (mStb && $stable(mAdr) && $stable(mSel) && $stable(mCti)))
   else
   begin
      failCount++;
      $error("stalled master beat changed");
   end

   // Incrementing beat is followed by another burst beat
   aBurstCont : assert property (@(posedge CLK) disable iff (RST_ASYNC)
      (mStb && !mStall && (mCti == `WBUF_CTI_INCR))
      |=> (mStb && ((mCti == `WBUF_CTI_INCR) || (mCti == `WBUF_CTI_END))))
   else
   begin
      failCount++;
      $error("burst did not continue after an incrementing beat");
   end

endmodule

bind wbufTop wbufAsserts uAsserts
(
   .CLK, .RST_ASYNC, .sCyc, .sStb, .sWe, .sStall, .sAck,
   .mCyc, .mStb, .mWe, .mStall, .mAdr, .mSel, .mCti
);

`default_nettype wire

//--- wbuf_consts.svh
/* Write buffer constants
   Depth, bus widths and Wishbone cycle type codes */
`ifndef WBUF_CONSTS_SVH
`define WBUF_CONSTS_SVH

// Number of buffer slots
`define WBUF_DEPTH 4

// Bus widths
`define WBUF_ADDR_W 32
`define WBUF_DATA_W 32
`define WBUF_SEL_W 4

////////////////////////////////////////
// Cycle type identifiers (CTI)
////////////////////////////////////////
`define WBUF_CTI_CLASSIC 3'd0
`define WBUF_CTI_INCR 3'd2
`define WBUF_CTI_END 3'd7

`endif
